//--- csr_cfg.svh
// ============================================================
// CSR block configuration
// Data width, mstatus field positions, FP field widths and
// the hardwired identity values
// ============================================================
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Data path
`define XLEN 32

// mstatus fields
`define MSTATUS_MIE_BIT  3   // Global machine interrupt enable
`define MSTATUS_MPIE_BIT 7   // MIE before the last trap
`define MSTATUS_MPP_LSB  11
`define MSTATUS_MPP_MSB  12  // Previous privilege, 2 bits

// Floating-point CSR fields
`define FFLAGS_W 5           // NV DZ OF UF NX
`define FRM_W    3           // Rounding mode

// Identity values
// MXL = 1 (RV32), extensions A D F I M
`define MISA_VALUE   32'h4000_1129
`define MIMPID_VALUE 32'h0000_0001

// Trap cause code width
`define CAUSE_W 5

`endif

//--- csr_pkg.sv
// ============================================================
// CSR types
// CSR addresses, instruction operations and privilege levels
// ============================================================
`default_nettype none

package csr_pkg;

  // Implemented CSR addresses
  typedef enum logic [11:0] {
    // Floating-point, user level
    CSR_FFLAGS    = 12'h001,
    CSR_FRM       = 12'h002,
    CSR_FCSR      = 12'h003,
    // Machine trap setup
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,  // Read only by rule
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    // Machine trap handling
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    // Machine information, read only by encoding
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14
  } csr_addr_e;

  // CSR instruction funct3
  typedef enum logic [2:0] {
    RW  = 3'b001,  // CSRRW
    RS  = 3'b010,  // CSRRS
    RC  = 3'b011,  // CSRRC
    RWI = 3'b101,  // Immediate forms
    RSI = 3'b110,
    RCI = 3'b111
  } csr_op_e;

  // Privilege levels
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

endpackage

`default_nettype wire

//--- csr_access_port.sv
// ============================================================
// CSR access port
// Address decode, legality checks, read mux, read-modify-write
// value and one write strobe per writable register
// ============================================================
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_access_port (
  input  csr_pkg::csr_addr_e    csr_addr,
  input  logic [`XLEN-1:0]      csr_wdata,     // rs1 or zero-extended uimm
  input  csr_pkg::csr_op_e      csr_op,
  input  logic                  csr_we,
  input  logic                  csr_access,
  input  csr_pkg::priv_e        current_priv,
  // Register values for the read mux
  input  logic [`XLEN-1:0]      mstatus,
  input  logic [`XLEN-1:0]      mie,
  input  logic [`XLEN-1:0]      mtvec,
  input  logic [`XLEN-1:0]      mscratch,
  input  logic [`XLEN-1:0]      mepc,
  input  logic [`XLEN-1:0]      mcause,
  input  logic [`XLEN-1:0]      mtval,
  input  logic [`FRM_W-1:0]     frm,
  input  logic [`FFLAGS_W-1:0]  fflags_fwd,    // Already merged with FPU flags
  output logic [`XLEN-1:0]      csr_rdata,
  output logic [`XLEN-1:0]      wr_value,
  output logic                  illegal_csr,
  // Write strobes
  output logic                  mstatus_wr,
  output logic                  mie_wr,
  output logic                  mtvec_wr,
  output logic                  mscratch_wr,
  output logic                  mepc_wr,
  output logic                  mcause_wr,
  output logic                  mtval_wr,
  output logic                  fflags_wr,
  output logic                  frm_wr
);

  logic             csr_exists;   // Address in implemented set
  logic             read_only;
  logic             priv_ok;
  logic             wr_ok;        // Legal write this cycle
  logic [`XLEN-1:0] rmw_value;

  // ==========================================================
  // Read mux and decode
  // ==========================================================
  always_comb begin
    csr_exists = 1'b1;
    case (csr_addr)
      csr_pkg::CSR_MSTATUS:   csr_rdata = mstatus;
      csr_pkg::CSR_MISA:      csr_rdata = `MISA_VALUE;
      csr_pkg::CSR_MIE:       csr_rdata = mie;
      csr_pkg::CSR_MTVEC:     csr_rdata = mtvec;
      csr_pkg::CSR_MSCRATCH:  csr_rdata = mscratch;
      csr_pkg::CSR_MEPC:      csr_rdata = mepc;
      csr_pkg::CSR_MCAUSE:    csr_rdata = mcause;
      csr_pkg::CSR_MTVAL:     csr_rdata = mtval;
      csr_pkg::CSR_MIMPID:    csr_rdata = `MIMPID_VALUE;
      // Vendor, arch and hart ids all zero
      csr_pkg::CSR_MVENDORID,
      csr_pkg::CSR_MARCHID,
      csr_pkg::CSR_MHARTID:   csr_rdata = '0;
      // Narrow FP registers, zero-extended
      csr_pkg::CSR_FFLAGS:    csr_rdata = {{(`XLEN-`FFLAGS_W){1'b0}}, fflags_fwd};
      csr_pkg::CSR_FRM:       csr_rdata = {{(`XLEN-`FRM_W){1'b0}}, frm};
      csr_pkg::CSR_FCSR:      csr_rdata = {{(`XLEN-`FRM_W-`FFLAGS_W){1'b0}}, frm, fflags_fwd};
      default: begin
        csr_exists = 1'b0;
        csr_rdata  = '0;                          // Unknown reads as zero
      end
    endcase
  end

  // ==========================================================
  // Legality
  // ==========================================================
  // Address bits 9:8 give the lowest privilege allowed
  assign priv_ok   = (current_priv >= csr_addr[9:8]);
  // Top two address bits set means read only
  assign read_only = (csr_addr[11:10] == 2'b11) || (csr_addr == csr_pkg::CSR_MISA);

  assign illegal_csr = csr_access &&
                       (!csr_exists || !priv_ok || (csr_we && read_only));

  assign wr_ok = csr_access && csr_we && !illegal_csr;

  // ==========================================================
  // Write value
  // ==========================================================
  always_comb begin
    case (csr_op)
      csr_pkg::RW, csr_pkg::RWI: rmw_value = csr_wdata;
      csr_pkg::RS, csr_pkg::RSI: rmw_value = csr_rdata | csr_wdata;   // Set bits
      csr_pkg::RC, csr_pkg::RCI: rmw_value = csr_rdata & ~csr_wdata;  // Clear bits
      default:                   rmw_value = csr_rdata;               // Reserved funct3
    endcase
  end

  // FP block sees the fcsr layout, so frm moves up past the flags
  assign wr_value = (csr_addr == csr_pkg::CSR_FRM) ? (rmw_value << `FFLAGS_W) : rmw_value;

  // Strobes
  assign mstatus_wr  = wr_ok && (csr_addr == csr_pkg::CSR_MSTATUS);
  assign mie_wr      = wr_ok && (csr_addr == csr_pkg::CSR_MIE);
  assign mtvec_wr    = wr_ok && (csr_addr == csr_pkg::CSR_MTVEC);
  assign mscratch_wr = wr_ok && (csr_addr == csr_pkg::CSR_MSCRATCH);
  assign mepc_wr     = wr_ok && (csr_addr == csr_pkg::CSR_MEPC);
  assign mcause_wr   = wr_ok && (csr_addr == csr_pkg::CSR_MCAUSE);
  assign mtval_wr    = wr_ok && (csr_addr == csr_pkg::CSR_MTVAL);
  // fcsr hits both FP registers
  assign fflags_wr   = wr_ok && ((csr_addr == csr_pkg::CSR_FFLAGS) ||
                                 (csr_addr == csr_pkg::CSR_FCSR));
  assign frm_wr      = wr_ok && ((csr_addr == csr_pkg::CSR_FRM) ||
                                 (csr_addr == csr_pkg::CSR_FCSR));

endmodule

`default_nettype wire

//--- csr_machine_regs.sv
// ============================================================
// Machine trap registers
// mstatus, mie, mtvec, mscratch, mepc, mcause, mtval with
// trap entry and MRET sequencing
// ============================================================
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_machine_regs (
  input  logic                clk,
  input  logic                reset_n,
  input  logic [`XLEN-1:0]    wr_value,
  // Write strobes from the access port
  input  logic                mstatus_wr,
  input  logic                mie_wr,
  input  logic                mtvec_wr,
  input  logic                mscratch_wr,
  input  logic                mepc_wr,
  input  logic                mcause_wr,
  input  logic                mtval_wr,
  // Trap and return
  input  logic                trap_entry,
  input  logic [`XLEN-1:0]    trap_pc,
  input  logic [`CAUSE_W-1:0] trap_cause,
  input  logic [`XLEN-1:0]    trap_val,
  input  logic                mret,
  input  csr_pkg::priv_e      current_priv,   // Saved into MPP on trap
  // Register values
  output logic [`XLEN-1:0]    mstatus,
  output logic [`XLEN-1:0]    mie,
  output logic [`XLEN-1:0]    mtvec,
  output logic [`XLEN-1:0]    mscratch,
  output logic [`XLEN-1:0]    mepc,
  output logic [`XLEN-1:0]    mcause,
  output logic [`XLEN-1:0]    mtval,
  // Status to the core
  output logic [`XLEN-1:0]    trap_vector,
  output logic [`XLEN-1:0]    mepc_out,
  output logic                mstatus_mie,
  output logic [1:0]          mpp_out
);

  // ==========================================================
  // Trap state: mstatus, mepc, mcause, mtval
  // ==========================================================
  // Priority is trap entry, then MRET, then CSR write
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mstatus <= '0;
      mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] <= csr_pkg::PRIV_M;  // Come up in M
      mepc    <= '0;
      mcause  <= '0;
      mtval   <= '0;
    end else if (trap_entry) begin
      mepc   <= trap_pc;
      mcause <= {{(`XLEN-`CAUSE_W){1'b0}}, trap_cause};  // Exceptions only, no int bit
      mtval  <= trap_val;
      mstatus[`MSTATUS_MPIE_BIT] <= mstatus[`MSTATUS_MIE_BIT];  // Stack MIE
      mstatus[`MSTATUS_MIE_BIT]  <= 1'b0;                       // Mask interrupts
      mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] <= current_priv;
    end else if (mret) begin
      mstatus[`MSTATUS_MIE_BIT]  <= mstatus[`MSTATUS_MPIE_BIT];  // Pop MIE
      mstatus[`MSTATUS_MPIE_BIT] <= 1'b1;
      mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] <= csr_pkg::PRIV_U;  // Least privileged
    end else begin
      // Only the three fields are writable
      if (mstatus_wr) begin
        mstatus[`MSTATUS_MIE_BIT]  <= wr_value[`MSTATUS_MIE_BIT];
        mstatus[`MSTATUS_MPIE_BIT] <= wr_value[`MSTATUS_MPIE_BIT];
        mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] <=
          wr_value[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB];
      end
      if (mepc_wr) begin
        mepc <= {wr_value[`XLEN-1:1], 1'b0};  // 2-byte aligned
      end
      if (mcause_wr) begin
        mcause <= wr_value;
      end
      if (mtval_wr) begin
        mtval <= wr_value;
      end
    end
  end

  // ==========================================================
  // Setup and scratch: mie, mtvec, mscratch
  // ==========================================================
  // Not touched by traps, so writes go through in any cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
    end else begin
      if (mie_wr) begin
        mie <= wr_value;
      end
      if (mtvec_wr) begin
        mtvec <= {wr_value[`XLEN-1:2], 2'b00};  // Direct mode only, word aligned
      end
      if (mscratch_wr) begin
        mscratch <= wr_value;
      end
    end
  end

  // Outputs to the core
  assign trap_vector = mtvec;                // All traps land in M
  assign mepc_out    = mepc;
  assign mstatus_mie = mstatus[`MSTATUS_MIE_BIT];
  assign mpp_out     = mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB];

endmodule

`default_nettype wire

//--- csr_fp_regs.sv
// ============================================================
// Floating-point CSRs
// fflags with sticky FPU accumulation and same-cycle read
// forwarding, plus frm
// ============================================================
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_fp_regs (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [`XLEN-1:0]     wr_value,    // fcsr layout, frm above flags
  input  logic                 fflags_wr,
  input  logic                 frm_wr,
  input  logic                 fflags_we,   // FPU flag update
  input  logic [`FFLAGS_W-1:0] fflags_in,
  output logic [`FFLAGS_W-1:0] fflags_fwd,
  output logic [`FRM_W-1:0]    frm_out,
  output logic [`FFLAGS_W-1:0] fflags_out
);

  logic [`FFLAGS_W-1:0] fflags;
  logic [`FRM_W-1:0]    frm;

  // Flags: CSR write wins, else OR in the FPU flags
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fflags <= '0;
    end else if (fflags_wr) begin
      fflags <= wr_value[`FFLAGS_W-1:0];
    end else if (fflags_we) begin
      fflags <= fflags | fflags_in;       // Sticky
    end
  end

  // Rounding mode, RNE after reset
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      frm <= '0;
    end else if (frm_wr) begin
      frm <= wr_value[`FFLAGS_W +: `FRM_W];
    end
  end

  // Read sees flags the FPU retires this cycle
  assign fflags_fwd = fflags_we ? (fflags | fflags_in) : fflags;

  assign frm_out    = frm;
  assign fflags_out = fflags;

endmodule

`default_nettype wire

//--- csr_file.sv
// ============================================================
// Machine-mode CSR file, RV32
// Access port steering the machine trap registers and the
// floating-point registers
// ============================================================
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_file (
  input  logic                 clk,
  input  logic                 reset_n,
  // CSR instruction
  input  csr_pkg::csr_addr_e   csr_addr,
  input  logic [`XLEN-1:0]     csr_wdata,
  input  csr_pkg::csr_op_e     csr_op,
  input  logic                 csr_we,
  input  logic                 csr_access,
  input  csr_pkg::priv_e       current_priv,
  output logic [`XLEN-1:0]     csr_rdata,
  output logic                 illegal_csr,
  // Trap entry and return
  input  logic                 trap_entry,
  input  logic [`XLEN-1:0]     trap_pc,
  input  logic [`CAUSE_W-1:0]  trap_cause,
  input  logic [`XLEN-1:0]     trap_val,
  input  logic                 mret,
  output logic [`XLEN-1:0]     trap_vector,
  output logic [`XLEN-1:0]     mepc_out,
  output logic                 mstatus_mie,
  output logic [1:0]           mpp_out,
  // FPU side
  input  logic                 fflags_we,
  input  logic [`FFLAGS_W-1:0] fflags_in,
  output logic [`FRM_W-1:0]    frm_out,
  output logic [`FFLAGS_W-1:0] fflags_out
);

  // Register values back to the read mux
  logic [`XLEN-1:0]     mstatus, mie, mtvec, mscratch, mepc, mcause, mtval;
  logic [`FFLAGS_W-1:0] fflags_fwd;
  // Write path
  logic [`XLEN-1:0]     wr_value;
  logic                 mstatus_wr, mie_wr, mtvec_wr, mscratch_wr;
  logic                 mepc_wr, mcause_wr, mtval_wr;
  logic                 fflags_wr, frm_wr;

  csr_access_port u_port (
    .csr_addr, .csr_wdata, .csr_op, .csr_we, .csr_access, .current_priv,
    .mstatus, .mie, .mtvec, .mscratch, .mepc, .mcause, .mtval,
    .frm         (frm_out),
    .fflags_fwd,
    .csr_rdata, .wr_value, .illegal_csr,
    .mstatus_wr, .mie_wr, .mtvec_wr, .mscratch_wr,
    .mepc_wr, .mcause_wr, .mtval_wr, .fflags_wr, .frm_wr
  );

  csr_machine_regs u_mregs (
    .clk, .reset_n, .wr_value,
    .mstatus_wr, .mie_wr, .mtvec_wr, .mscratch_wr,
    .mepc_wr, .mcause_wr, .mtval_wr,
    .trap_entry, .trap_pc, .trap_cause, .trap_val, .mret, .current_priv,
    .mstatus, .mie, .mtvec, .mscratch, .mepc, .mcause, .mtval,
    .trap_vector, .mepc_out, .mstatus_mie, .mpp_out
  );

  csr_fp_regs u_fpregs (
    .clk, .reset_n, .wr_value, .fflags_wr, .frm_wr,
    .fflags_we, .fflags_in,
    .fflags_fwd, .frm_out, .fflags_out
  );

endmodule

`default_nettype wire

//--- csr_asserts.sv
// ============================================================
// CSR file properties
// Bound into the CSR file top level
// ============================================================
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_asserts (
  input logic             clk,
  input logic             reset_n,
  input logic             csr_access,
  input logic             illegal_csr,
  input logic             trap_entry,
  input logic [`XLEN-1:0] mtvec,
  input logic [`XLEN-1:0] mstatus
);

  int fail_count = 0;     // Read by the testbench at the end

  // No illegal flag without an access
  illegal_needs_access: assert property (
    @(posedge clk) disable iff (!reset_n) !csr_access |-> !illegal_csr
  ) else begin
    $error("illegal_csr high while csr_access is low");
    fail_count++;
  end

  // Trap vector word aligned
  mtvec_aligned: assert property (
    @(posedge clk) disable iff (!reset_n) mtvec[1:0] == 2'b00
  ) else begin
    $error("mtvec bits 1:0 not zero");
    fail_count++;
  end

  // Interrupts masked after trap entry
  trap_clears_mie: assert property (
    @(posedge clk) disable iff (!reset_n) trap_entry |=> !mstatus[`MSTATUS_MIE_BIT]
  ) else begin
    $error("mstatus MIE still set the cycle after trap entry");
    fail_count++;
  end

endmodule

`default_nettype wire

//--- tb_csr_file.sv
// ============================================================
// CSR file testbench
// LFSR-driven CSR operations, traps, MRET and FPU flag updates
// checked against a reference model of the register state
// ============================================================
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module tb_csr_file;

  // Cycle budget, one cycle per applied stimulus
  localparam int RESET_CYCLES = 16;
  localparam int T1_OPS = 300, T4_TRAPS = 30, T5_RETS = 30, T6_OPS = 200;
  localparam int RUN_CYCLES = RESET_CYCLES + 2 + (T1_OPS + 10) + 40 + 40 +
                              6 * T4_TRAPS + 4 * T5_RETS + (T6_OPS + 3);
  localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;
  localparam logic [`XLEN-1:0] MSTATUS_MASK = (32'h1 << `MSTATUS_MIE_BIT) |
                                              (32'h1 << `MSTATUS_MPIE_BIT) |
                                              (32'h3 << `MSTATUS_MPP_LSB);
  localparam logic [`XLEN-1:0] MISA_EXP = (32'h1 << 30) |  // MXL = 1
                                          (32'h1 << 0) | (32'h1 << 3) | (32'h1 << 5) |
                                          (32'h1 << 8) | (32'h1 << 12);  // A D F I M

  logic clk, reset_n;
  csr_pkg::csr_addr_e csr_addr;
  csr_pkg::csr_op_e csr_op;
  csr_pkg::priv_e current_priv;
  logic [`XLEN-1:0] csr_wdata, trap_pc, trap_val, csr_rdata, trap_vector, mepc_out;
  logic csr_we, csr_access, trap_entry, mret, fflags_we, illegal_csr, mstatus_mie;
  logic [`CAUSE_W-1:0] trap_cause;
  logic [`FFLAGS_W-1:0] fflags_in, fflags_out;
  logic [`FRM_W-1:0] frm_out;
  logic [1:0] mpp_out;

  // Stimulus for the next cycle, strobes are one-shot
  logic n_access = 1'b0, n_we = 1'b0, n_trap = 1'b0, n_mret = 1'b0, n_fwe = 1'b0;
  csr_pkg::csr_addr_e n_addr = csr_pkg::CSR_MSTATUS;
  csr_pkg::csr_op_e n_op = csr_pkg::RS;
  csr_pkg::priv_e n_priv = csr_pkg::PRIV_M;
  logic [`XLEN-1:0] n_wdata = '0, n_pc = '0, n_tval = '0, n_cause = '0, n_fin = '0;

  // Reference model, reset values
  logic [`XLEN-1:0] m_mstatus = 32'h3 << `MSTATUS_MPP_LSB;  // MPP = M
  logic [`XLEN-1:0] m_mie = '0, m_mtvec = '0, m_mscratch = '0;
  logic [`XLEN-1:0] m_mepc = '0, m_mcause = '0, m_mtval = '0;
  logic [`FFLAGS_W-1:0] m_fflags = '0;
  logic [`FRM_W-1:0] m_frm = '0;

  logic [15:0] lfsr = 16'd40084;
  string test_name = "none";
  int errors = 0, test_errors = 0, checks = 0, tests_run = 0, cycle_count = 0;

  csr_pkg::csr_addr_e writable [10] = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE,
    csr_pkg::CSR_MTVEC, csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE,
    csr_pkg::CSR_MTVAL, csr_pkg::CSR_FFLAGS, csr_pkg::CSR_FRM, csr_pkg::CSR_FCSR};
  csr_pkg::csr_addr_e id_regs [5] = '{csr_pkg::CSR_MISA, csr_pkg::CSR_MVENDORID,
    csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID, csr_pkg::CSR_MHARTID};
  csr_pkg::csr_addr_e trap_targets [4] = '{csr_pkg::CSR_MEPC, csr_pkg::CSR_MTVEC,
    csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MIE};
  csr_pkg::csr_addr_e ret_targets [2] = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MEPC};
  csr_pkg::csr_op_e ops [6] = '{csr_pkg::RW, csr_pkg::RS, csr_pkg::RC,
    csr_pkg::RWI, csr_pkg::RSI, csr_pkg::RCI};
  csr_pkg::priv_e privs [4] = '{csr_pkg::PRIV_U, csr_pkg::PRIV_S,
    csr_pkg::PRIV_M, csr_pkg::PRIV_M};              // M twice, more legal writes
  logic [11:0] bad_addrs [5] = '{12'h100, 12'h180, 12'h302, 12'h344, 12'h7C0};

  csr_file dut0 (.*);

  bind csr_file csr_asserts asserts0 (.clk(clk), .reset_n(reset_n),
    .csr_access(csr_access), .illegal_csr(illegal_csr), .trap_entry(trap_entry),
    .mtvec(mtvec), .mstatus(mstatus));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois LFSR, x^16+x^14+x^13+x^11+1, one step per bit
  function automatic logic [`XLEN-1:0] rand_bits(input int n);
    logic [`XLEN-1:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[`XLEN-2:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic addr_known(input csr_pkg::csr_addr_e a);
    case (a)
      csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MISA, csr_pkg::CSR_MIE, csr_pkg::CSR_MTVEC,
      csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL,
      csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID,
      csr_pkg::CSR_MHARTID, csr_pkg::CSR_FFLAGS, csr_pkg::CSR_FRM,
      csr_pkg::CSR_FCSR: return 1'b1;
      default:           return 1'b0;
    endcase
  endfunction

  // Expected read, flags merged with an FPU update in the same cycle
  function automatic logic [`XLEN-1:0] model_read(input csr_pkg::csr_addr_e a);
    logic [`FFLAGS_W-1:0] fl;
    fl = n_fwe ? (m_fflags | n_fin[`FFLAGS_W-1:0]) : m_fflags;
    case (a)
      csr_pkg::CSR_MSTATUS:  return m_mstatus;
      csr_pkg::CSR_MISA:     return MISA_EXP;
      csr_pkg::CSR_MIE:      return m_mie;
      csr_pkg::CSR_MTVEC:    return m_mtvec;
      csr_pkg::CSR_MSCRATCH: return m_mscratch;
      csr_pkg::CSR_MEPC:     return m_mepc;
      csr_pkg::CSR_MCAUSE:   return m_mcause;
      csr_pkg::CSR_MTVAL:    return m_mtval;
      csr_pkg::CSR_MIMPID:   return 32'h1;
      csr_pkg::CSR_FFLAGS:   return {27'b0, fl};
      csr_pkg::CSR_FRM:      return {29'b0, m_frm};
      csr_pkg::CSR_FCSR:     return {24'b0, m_frm, fl};
      default:               return '0;           // Ids and unknown addresses
    endcase
  endfunction

  task automatic check_value(input string what, input logic [`XLEN-1:0] exp,
                             input logic [`XLEN-1:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      test_errors++;
      $display("ERR %s: %s expected %h, actual %h", test_name, what, exp, got);
    end
  endtask

  task automatic drive_inputs();
    csr_access   <= n_access;
    csr_we       <= n_we;
    csr_addr     <= n_addr;
    csr_op       <= n_op;
    csr_wdata    <= n_wdata;
    current_priv <= n_priv;
    trap_entry   <= n_trap;
    trap_pc      <= n_pc;
    trap_cause   <= n_cause[`CAUSE_W-1:0];
    trap_val     <= n_tval;
    mret         <= n_mret;
    fflags_we    <= n_fwe;
    fflags_in    <= n_fin[`FFLAGS_W-1:0];
  endtask

  // Drive on the rising edge, check mid-cycle, then advance the model
  task automatic apply_cycle();
    logic [`XLEN-1:0] rd, wv;
    logic ill, wr;
    @(posedge clk);
    drive_inputs();
    @(negedge clk);
    ill = n_access && (!addr_known(n_addr) || (n_priv < n_addr[9:8]) ||
          (n_we && ((n_addr[11:10] == 2'b11) || (n_addr == csr_pkg::CSR_MISA))));
    rd = model_read(n_addr);
    check_value("illegal_csr", ill, illegal_csr);
    if (n_access && (!ill || !addr_known(n_addr))) check_value("csr_rdata", rd, csr_rdata);
    check_value("trap_vector", m_mtvec, trap_vector);
    check_value("mepc_out", m_mepc, mepc_out);
    check_value("mstatus_mie", m_mstatus[`MSTATUS_MIE_BIT], mstatus_mie);
    check_value("mpp_out", m_mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB], mpp_out);
    check_value("frm_out", m_frm, frm_out);
    check_value("fflags_out", m_fflags, fflags_out);
    wr = n_access && n_we && !ill;
    case (n_op)
      csr_pkg::RW, csr_pkg::RWI: wv = n_wdata;
      csr_pkg::RS, csr_pkg::RSI: wv = rd | n_wdata;
      default:                   wv = rd & ~n_wdata;
    endcase
    if (n_trap) begin                                  // Trap beats MRET and writes
      m_mepc = n_pc;
      m_mcause = {27'b0, n_cause[`CAUSE_W-1:0]};
      m_mtval = n_tval;
      m_mstatus[`MSTATUS_MPIE_BIT] = m_mstatus[`MSTATUS_MIE_BIT];
      m_mstatus[`MSTATUS_MIE_BIT] = 1'b0;
      m_mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] = n_priv;
    end else if (n_mret) begin
      m_mstatus[`MSTATUS_MIE_BIT] = m_mstatus[`MSTATUS_MPIE_BIT];
      m_mstatus[`MSTATUS_MPIE_BIT] = 1'b1;
      m_mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] = csr_pkg::PRIV_U;
    end else if (wr) begin
      case (n_addr)
        csr_pkg::CSR_MSTATUS: m_mstatus = wv & MSTATUS_MASK;
        csr_pkg::CSR_MEPC:    m_mepc = wv & ~32'h1;
        csr_pkg::CSR_MCAUSE:  m_mcause = wv;
        csr_pkg::CSR_MTVAL:   m_mtval = wv;
        default: ;
      endcase
    end
    if (wr) begin                                      // Untouched by trap and MRET
      case (n_addr)
        csr_pkg::CSR_MIE:      m_mie = wv;
        csr_pkg::CSR_MTVEC:    m_mtvec = wv & ~32'h3;
        csr_pkg::CSR_MSCRATCH: m_mscratch = wv;
        csr_pkg::CSR_FRM:      m_frm = wv[`FRM_W-1:0];
        csr_pkg::CSR_FCSR:     m_frm = wv[`FFLAGS_W +: `FRM_W];
        default: ;
      endcase
    end
    if (wr && ((n_addr == csr_pkg::CSR_FFLAGS) || (n_addr == csr_pkg::CSR_FCSR)))
      m_fflags = wv[`FFLAGS_W-1:0];                    // Write wins over FPU
    else if (n_fwe)
      m_fflags = m_fflags | n_fin[`FFLAGS_W-1:0];      // Sticky
    n_access = 1'b0;
    n_we = 1'b0;
    n_trap = 1'b0;
    n_mret = 1'b0;
    n_fwe = 1'b0;
  endtask

  // Random op form, uimm for the immediate forms
  task automatic rand_access(input csr_pkg::csr_addr_e a);
    n_access = 1'b1;
    n_addr = a;
    n_op = ops[rand_bits(3) % 6];
    n_we = (rand_bits(2) != 0);
    n_wdata = n_op[2] ? rand_bits(5) : rand_bits(`XLEN);
  endtask

  task automatic read_csr(input csr_pkg::csr_addr_e a);
    n_access = 1'b1;
    n_addr = a;
    n_op = csr_pkg::RS;
    n_wdata = '0;
    apply_cycle();
  endtask

  task automatic read_all();
    foreach (writable[i]) read_csr(writable[i]);
  endtask

  task automatic set_trap();
    n_trap = 1'b1;
    n_pc = rand_bits(`XLEN);
    n_cause = rand_bits(`CAUSE_W);
    n_tval = rand_bits(`XLEN);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    $display("%-10s done, %0d errors", test_name, test_errors);
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    reset_n <= 1'b0;
    drive_inputs();
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;

    start_test("reset");
    apply_cycle();
    read_csr(csr_pkg::CSR_MSTATUS);
    end_test();

    start_test("rand_ops");
    repeat (T1_OPS) begin
      rand_access(writable[rand_bits(4) % 10]);
      apply_cycle();
    end
    read_all();
    end_test();

    start_test("identity");
    foreach (id_regs[i]) begin
      read_csr(id_regs[i]);
      rand_access(id_regs[i]);
      n_we = 1'b1;                                     // Always refused
      apply_cycle();
    end
    foreach (bad_addrs[i]) begin
      rand_access(csr_pkg::csr_addr_e'(bad_addrs[i]));
      apply_cycle();
    end
    read_all();
    end_test();

    start_test("user_mode");
    n_priv = csr_pkg::PRIV_U;
    foreach (writable[i]) begin
      rand_access(writable[i]);                        // FP ones stay legal
      apply_cycle();
    end
    foreach (id_regs[i]) begin
      rand_access(id_regs[i]);
      apply_cycle();
    end
    n_priv = csr_pkg::PRIV_M;
    read_all();
    end_test();

    start_test("trap_entry");
    repeat (T4_TRAPS) begin
      rand_access(csr_pkg::CSR_MSTATUS);
      n_op = csr_pkg::RW;
      n_we = 1'b1;
      apply_cycle();
      set_trap();
      n_priv = privs[rand_bits(2)];
      rand_access(trap_targets[rand_bits(2)]);         // mepc write gets dropped
      n_we = 1'b1;
      apply_cycle();
      n_priv = csr_pkg::PRIV_M;
      read_csr(csr_pkg::CSR_MEPC);
      read_csr(csr_pkg::CSR_MCAUSE);
      read_csr(csr_pkg::CSR_MTVAL);
      read_csr(csr_pkg::CSR_MSTATUS);
    end
    end_test();

    start_test("mret");
    repeat (T5_RETS) begin
      rand_access(csr_pkg::CSR_MSTATUS);
      n_op = csr_pkg::RW;
      n_we = 1'b1;
      apply_cycle();
      if (rand_bits(3) == 0) set_trap();               // Trap wins now and then
      n_mret = 1'b1;
      rand_access(ret_targets[rand_bits(1)]);
      n_we = 1'b1;
      apply_cycle();
      read_csr(csr_pkg::CSR_MSTATUS);
      read_csr(csr_pkg::CSR_MEPC);
    end
    end_test();

    start_test("fp_flags");
    repeat (T6_OPS) begin
      n_fwe = (rand_bits(1) != 0);
      n_fin = rand_bits(`FFLAGS_W);
      n_priv = privs[rand_bits(2)];
      if (rand_bits(1) != 0) rand_access(writable[7 + rand_bits(2) % 3]);
      apply_cycle();
    end
    n_priv = csr_pkg::PRIV_M;
    read_csr(csr_pkg::CSR_FFLAGS);
    read_csr(csr_pkg::CSR_FRM);
    read_csr(csr_pkg::CSR_FCSR);
    end_test();

    errors += dut0.asserts0.fail_count;               // Bound property failures
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout, tests still running after %0d cycles", cycle_count);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
csr_pkg.sv
csr_access_port.sv
csr_machine_regs.sv
csr_fp_regs.sv
csr_file.sv
csr_asserts.sv
tb_csr_file.sv

//--- Bender.yml
package:
  name: csr_file

export_include_dirs:
  - .

sources:
  - csr_pkg.sv
  - csr_access_port.sv
  - csr_machine_regs.sv
  - csr_fp_regs.sv
  - csr_file.sv
  - target: test
    files:
      - csr_asserts.sv
      - tb_csr_file.sv
